// ==== Makefile ====
VERILATOR ?= verilator
TOP       := mem_access_tb
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, the binary may stop early on an assertion
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/mem_access_assert.sv ====
// concurrent checks bound into the control FSM, strobe width,
// memory access in idle and status exclusivity
`timescale 1ns/1ps
`default_nettype none

module mem_access_assert (
  input wire        user_clk,
  input wire        user_aresetn,
  input wire [1:0]  state,
  input wire        mem_en,
  input wire        wr_sts_valid,
  input wire        rd_sts_valid
);

  wr_sts_pulse: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    wr_sts_valid |=> !wr_sts_valid)
    else $error("write status strobe held longer than one cycle");

  rd_sts_pulse: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    rd_sts_valid |=> !rd_sts_valid)
    else $error("read status strobe held longer than one cycle");

  idle_no_mem: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    (state == mem_pkg::st_idle) |-> !mem_en)
    else $error("memory enabled while the FSM is idle");

  sts_exclusive: assert property (@(posedge user_clk) disable iff (!user_aresetn)
    !(wr_sts_valid && rd_sts_valid))
    else $error("read and write status strobes in the same cycle");

endmodule

bind mem_ctrl mem_access_assert ctrl_chk (
  .user_clk     (user_clk),
  .user_aresetn (user_aresetn),
  .state        (state_q),
  .mem_en       (mem_en),
  .wr_sts_valid (wr_sts_valid),
  .rd_sts_valid (rd_sts_valid)
);

`default_nettype wire

// ==== dv/mem_access_tb.sv ====
// testbench for the memory access engine, byte-level reference model
// drives commands and write beats, checks read beats, statuses and counters
`timescale 1ns/1ps
`default_nettype none

module mem_access_tb;

  localparam int clk_period  = 8;
  localparam int num_pairs   = 12;                 // random write then read pairs
  localparam int num_partial = 3;
  localparam int num_bad     = 9;                  // rejected commands and their readbacks
  localparam int max_len     = 96;                 // longest random transfer in bytes
  localparam int max_beats   = max_len / mem_pkg::data_bytes;
  localparam int max_gap     = 2;                  // idle cycles between write beats

  typedef struct packed {
    logic [31:0]                     cyc;          // cycle the beat is due
    logic [mem_pkg::data_w-1:0]      data;
    logic [mem_pkg::data_bytes-1:0]  keep;
    logic                            last;
  } beat_t;

  typedef struct packed {
    logic [31:0]                cyc;
    logic [mem_pkg::sts_w-1:0]  sts;
  } sts_t;

  logic                            user_clk = 1'b0;
  logic                            user_aresetn;
  logic                            wr_cmd_valid;
  logic [mem_pkg::addr_w-1:0]      wr_cmd_addr;
  logic [mem_pkg::len_w-1:0]       wr_cmd_len;
  logic                            rd_cmd_valid;
  logic [mem_pkg::addr_w-1:0]      rd_cmd_addr;
  logic [mem_pkg::len_w-1:0]       rd_cmd_len;
  logic                            wr_data_valid;
  logic [mem_pkg::data_w-1:0]      wr_data;
  logic [mem_pkg::data_bytes-1:0]  wr_keep;
  logic                            wr_last;
  logic [mem_pkg::stat_sel_w-1:0]  stat_sel;
  wire                             rd_data_valid;
  wire  [mem_pkg::data_w-1:0]      rd_data;
  wire  [mem_pkg::data_bytes-1:0]  rd_keep;
  wire                             rd_last;
  wire  [mem_pkg::stat_w-1:0]      stat_value;
  wire                             wr_sts_valid;
  wire  [mem_pkg::sts_w-1:0]       wr_sts_data;
  wire                             rd_sts_valid;
  wire  [mem_pkg::sts_w-1:0]       rd_sts_data;

  logic [7:0] ref_mem [mem_pkg::mem_bytes];                  // byte model of the memory
  int         exp_stat [mem_pkg::num_stats] = '{default: 0};  // model counters
  beat_t      exp_beats [$];
  sts_t       exp_wr_sts [$];
  sts_t       exp_rd_sts [$];
  int         cyc = 0;                                       // rising edges so far
  logic       checking = 1'b0;
  bit         run_done = 1'b0;
  int         val_errs = 0;
  int         other_errs = 0;

  mem_access_top uut (.*);

  always #(clk_period / 2) user_clk = ~user_clk;

  function automatic logic [mem_pkg::sts_w-1:0] ref_status(input int addr, input int len);
    logic [mem_pkg::sts_w-1:0] s;
    s = '0;
    if (addr % mem_pkg::data_bytes != 0) begin
      s[mem_pkg::sts_align_bit] = 1'b1;             // checked first
    end else if (len == 0) begin
      s[mem_pkg::sts_zero_bit] = 1'b1;
    end else if (addr + len > mem_pkg::mem_bytes) begin
      s[mem_pkg::sts_range_bit] = 1'b1;
    end else begin
      s[mem_pkg::sts_ok_bit] = 1'b1;
    end
    return s;
  endfunction

  // keep of the final beat, low len mod 8 bytes
  function automatic logic [mem_pkg::data_bytes-1:0] ref_tail_keep(input int len);
    int r;
    r = len % mem_pkg::data_bytes;
    if (r == 0) return '1;
    return mem_pkg::data_bytes'((1 << r) - 1);
  endfunction

  function automatic logic [mem_pkg::data_w-1:0] ref_word(input int word);
    logic [mem_pkg::data_w-1:0] w;
    for (int i = 0; i < mem_pkg::data_bytes; i++) w[i*8 +: 8] = ref_mem[word*8 + i];
    return w;
  endfunction

  // fill value of one byte, every address bit takes part
  function automatic logic [mem_pkg::data_w-1:0] fill_word(input int word);
    logic [mem_pkg::data_w-1:0] w;
    int                         a;
    for (int i = 0; i < mem_pkg::data_bytes; i++) begin
      a = word * mem_pkg::data_bytes + i;
      w[i*8 +: 8] = 8'(a) ^ 8'((a >> 8) * 8'h4d);
    end
    return w;
  endfunction

  function automatic int ref_stat(input int idx);
    return (idx < mem_pkg::num_stats) ? exp_stat[idx] : 0;   // unused index reads 0
  endfunction

  task automatic value_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] want);
    val_errs++;
    $display("error at %0t: %s got %0h expected %0h", $time, name, got, want);
  endtask

  task automatic report_failure(input string what);
    other_errs++;
    $display("at %0t: %s", $time, what);
  endtask

  task automatic send_write(input int addr, input int len, input bit fill);
    logic [mem_pkg::sts_w-1:0]       sts;
    logic [mem_pkg::data_bytes-1:0]  keep;
    logic [mem_pkg::data_w-1:0]      data;
    int                              beats;
    int                              word;
    sts   = ref_status(addr, len);
    beats = (len + mem_pkg::data_bytes - 1) / mem_pkg::data_bytes;
    @(posedge user_clk);
    wr_cmd_valid <= 1'b1;
    wr_cmd_addr  <= mem_pkg::addr_w'(addr);
    wr_cmd_len   <= mem_pkg::len_w'(len);
    exp_stat[mem_pkg::stat_wr_cmd]++;
    exp_stat[mem_pkg::stat_wr_sts]++;
    if (!sts[mem_pkg::sts_ok_bit]) begin
      exp_stat[mem_pkg::stat_wr_err]++;
      exp_wr_sts.push_back('{cyc + 3, sts});        // rejected, no data beats
    end
    @(posedge user_clk);
    wr_cmd_valid <= 1'b0;
    if (sts[mem_pkg::sts_ok_bit]) begin
      for (int k = 0; k < beats; k++) begin
        repeat (fill ? 0 : $urandom_range(max_gap, 0)) begin
          wr_data_valid <= 1'b0;                    // gap between beats
          @(posedge user_clk);
        end
        word = addr / mem_pkg::data_bytes + k;
        data = fill ? fill_word(word) : {$urandom, $urandom};
        keep = fill ? '1 : mem_pkg::data_bytes'($urandom);
        if (k == beats - 1) keep = keep & ref_tail_keep(len);
        wr_data_valid <= 1'b1;
        wr_data       <= data;
        wr_keep       <= keep;
        wr_last       <= (k == beats - 1);
        for (int b = 0; b < mem_pkg::data_bytes; b++) begin
          if (keep[b]) ref_mem[word*mem_pkg::data_bytes + b] = data[b*8 +: 8];
        end
        exp_stat[mem_pkg::stat_wr_word]++;
        exp_stat[mem_pkg::stat_wr_bytes] += $countones(keep);
        if (k == beats - 1) begin
          exp_stat[mem_pkg::stat_wr_pkt]++;
          exp_wr_sts.push_back('{cyc + 3, sts});    // two cycles after the final beat
        end
        @(posedge user_clk);
      end
      wr_data_valid <= 1'b0;
      wr_last       <= 1'b0;
    end
    while (!wr_sts_valid) @(posedge user_clk);
  endtask

  task automatic send_read(input int addr, input int len);
    logic [mem_pkg::sts_w-1:0] sts;
    beat_t                     b;
    int                        beats;
    int                        c0;
    sts   = ref_status(addr, len);
    beats = (len + mem_pkg::data_bytes - 1) / mem_pkg::data_bytes;
    @(posedge user_clk);
    c0 = cyc;
    rd_cmd_valid <= 1'b1;
    rd_cmd_addr  <= mem_pkg::addr_w'(addr);
    rd_cmd_len   <= mem_pkg::len_w'(len);
    exp_stat[mem_pkg::stat_rd_cmd]++;
    exp_stat[mem_pkg::stat_rd_sts]++;
    if (!sts[mem_pkg::sts_ok_bit]) begin
      exp_stat[mem_pkg::stat_rd_err]++;
      exp_rd_sts.push_back('{c0 + 3, sts});
    end else begin
      for (int k = 0; k < beats; k++) begin
        b.cyc  = c0 + 4 + k;                        // first beat 3 cycles after the strobe
        b.data = ref_word(addr / mem_pkg::data_bytes + k);
        b.last = (k == beats - 1);
        b.keep = b.last ? ref_tail_keep(len) : '1;
        exp_beats.push_back(b);
        exp_stat[mem_pkg::stat_rd_word]++;
        exp_stat[mem_pkg::stat_rd_bytes] += $countones(b.keep);
        if (b.last) exp_stat[mem_pkg::stat_rd_pkt]++;
      end
      exp_rd_sts.push_back('{c0 + 4 + beats, sts}); // one cycle after the last beat
    end
    @(posedge user_clk);
    rd_cmd_valid <= 1'b0;
    while (!rd_sts_valid) @(posedge user_clk);
  endtask

  task automatic check_beat();
    beat_t e;
    assert (exp_beats.size() != 0) else report_failure("read beat arrived with none expected");
    if (exp_beats.size() != 0) begin
      e = exp_beats.pop_front();
      assert (cyc == e.cyc) else value_mismatch("rd_data_valid cycle", cyc, e.cyc);
      assert (rd_data === e.data) else value_mismatch("rd_data", rd_data, e.data);
      assert (rd_keep === e.keep) else value_mismatch("rd_keep", rd_keep, e.keep);
      assert (rd_last === e.last) else value_mismatch("rd_last", rd_last, e.last);
    end
  endtask

  task automatic check_status(input bit is_wr, input logic [mem_pkg::sts_w-1:0] got);
    sts_t e;
    int   n;
    n = is_wr ? exp_wr_sts.size() : exp_rd_sts.size();
    assert (n != 0) else report_failure("status strobe arrived with none expected");
    if (n != 0) begin
      if (is_wr) e = exp_wr_sts.pop_front();
      else e = exp_rd_sts.pop_front();
      assert (cyc == e.cyc)
        else value_mismatch(is_wr ? "wr_sts_valid cycle" : "rd_sts_valid cycle", cyc, e.cyc);
      assert (got === e.sts)
        else value_mismatch(is_wr ? "wr_sts_data" : "rd_sts_data", got, e.sts);
    end
  endtask

  task automatic check_stat(input int idx);
    logic [mem_pkg::stat_w-1:0] want;
    @(posedge user_clk);
    stat_sel <= mem_pkg::stat_sel_w'(idx);
    repeat (3) @(posedge user_clk);                 // index and value registers
    want = ref_stat(idx);
    assert (stat_value === want)
      else value_mismatch($sformatf("stat_value[%0d]", idx), stat_value, want);
  endtask

  // comparing process, every output strobe against the model queues
  always @(posedge user_clk) begin
    cyc <= cyc + 1;
    if (checking) begin
      if (rd_data_valid) check_beat();
      if (wr_sts_valid) check_status(1'b1, wr_sts_data);
      if (rd_sts_valid) check_status(1'b0, rd_sts_data);
    end
  end

  initial begin : stimulus
    int addr;
    int len;
    void'($urandom(32'hb50ac6ef));
    user_aresetn  <= 1'b0;
    wr_cmd_valid  <= 1'b0;
    wr_cmd_addr   <= '0;
    wr_cmd_len    <= '0;
    rd_cmd_valid  <= 1'b0;
    rd_cmd_addr   <= '0;
    rd_cmd_len    <= '0;
    wr_data_valid <= 1'b0;
    wr_data       <= '0;
    wr_keep       <= '0;
    wr_last       <= 1'b0;
    stat_sel      <= '0;
    repeat (16) @(posedge user_clk);
    user_aresetn <= 1'b1;
    @(posedge user_clk);
    assert (!rd_data_valid && !wr_sts_valid && !rd_sts_valid)
      else report_failure("a valid output is high after reset");
    checking <= 1'b1;

    send_write(0, mem_pkg::mem_bytes, 1'b1);        // defined contents everywhere
    send_read(0, mem_pkg::mem_bytes);
    for (int i = 0; i < num_pairs; i++) begin
      addr = mem_pkg::data_bytes * $urandom_range(mem_pkg::mem_words - 1, 0);
      len  = $urandom_range((mem_pkg::mem_bytes - addr < max_len) ?
                            mem_pkg::mem_bytes - addr : max_len, 1);
      send_write(addr, len, 1'b0);
      send_read(addr, len);
    end

    send_write(64, 13, 1'b0);                       // partial last beats
    send_read(64, 24);                              // neighbour words too
    send_write(200, 5, 1'b0);
    send_read(192, 24);
    send_write(1000, 31, 1'b0);
    send_read(1000, 31);

    send_write(2043, 16, 1'b0);                     // misaligned and past the end
    send_write(8, 0, 1'b0);                         // zero length
    send_write(2040, 16, 1'b0);                     // past the end
    send_write(0, 4095, 1'b0);
    send_read(5, 0);                                // misaligned and zero length
    send_read(16, 0);
    send_read(2000, 100);
    send_read(0, 24);                               // untouched by rejected writes
    send_read(2040, 8);                             // last word, exactly in range

    for (int i = 0; i <= mem_pkg::num_stats; i++) check_stat(i);

    repeat (4) @(posedge user_clk);
    assert (exp_beats.size() == 0 && exp_wr_sts.size() == 0 && exp_rd_sts.size() == 0)
      else report_failure("expected read beats or statuses never arrived");
    $display("value errors %0d, other errors %0d", val_errs, other_errs);
    run_done = 1'b1;
    if (val_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // planned beats and statuses plus margin
  initial begin : watchdog
    int budget;
    budget = 32 + 4 * (mem_pkg::mem_words + 8)
           + (num_pairs + num_partial) * 2 * (max_beats * (max_gap + 1) + 8)
           + num_bad * 12 + (mem_pkg::num_stats + 1) * 5 + 100;
    #(budget * clk_period);
    run_done = 1'b1;
    $display("timeout, the run did not finish within %0d cycles", budget);
    $display("Test failures found");
    $finish;
  end

  // run cut short before the closing line
  final begin
    if (!run_done) $display("Test failures found");
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/mem_pkg.sv
src/mem_ctrl.sv
src/mem_array.sv
src/read_stream_out.sv
src/mem_stats.sv
src/mem_access_top.sv
dv/mem_access_assert.sv
dv/mem_access_tb.sv

// ==== src/mem_access_top.sv ====
// memory access engine top, joins command control, word memory,
// read stream output stage and traffic statistics
`timescale 1ns/1ps
`default_nettype none

module mem_access_top (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  input  wire                             wr_cmd_valid,
  input  wire  [mem_pkg::addr_w-1:0]      wr_cmd_addr,
  input  wire  [mem_pkg::len_w-1:0]       wr_cmd_len,
  input  wire                             rd_cmd_valid,
  input  wire  [mem_pkg::addr_w-1:0]      rd_cmd_addr,
  input  wire  [mem_pkg::len_w-1:0]       rd_cmd_len,
  input  wire                             wr_data_valid,
  input  wire  [mem_pkg::data_w-1:0]      wr_data,
  input  wire  [mem_pkg::data_bytes-1:0]  wr_keep,
  input  wire                             wr_last,
  input  wire  [mem_pkg::stat_sel_w-1:0]  stat_sel,
  output wire                             rd_data_valid,
  output wire  [mem_pkg::data_w-1:0]      rd_data,
  output wire  [mem_pkg::data_bytes-1:0]  rd_keep,
  output wire                             rd_last,
  output wire  [mem_pkg::stat_w-1:0]      stat_value,
  output wire                             wr_sts_valid,
  output wire  [mem_pkg::sts_w-1:0]       wr_sts_data,
  output wire                             rd_sts_valid,
  output wire  [mem_pkg::sts_w-1:0]       rd_sts_data
);

  wire                              mem_en;
  wire [mem_pkg::data_bytes-1:0]    mem_we;
  wire [mem_pkg::word_addr_w-1:0]   mem_addr;
  wire [mem_pkg::data_w-1:0]        mem_wdata;
  wire [mem_pkg::data_w-1:0]        mem_rdata;
  wire [mem_pkg::data_bytes-1:0]    rd_beat_keep;
  wire                              rd_beat_last;
  wire                              rd_issue;

  // a read beat always keeps at least one byte, idle and write cycles keep none
  assign rd_issue = |rd_beat_keep;

  mem_ctrl ctrl_inst (
    .user_clk      (user_clk),
    .user_aresetn  (user_aresetn),
    .wr_cmd_valid  (wr_cmd_valid),
    .wr_cmd_addr   (wr_cmd_addr),
    .wr_cmd_len    (wr_cmd_len),
    .rd_cmd_valid  (rd_cmd_valid),
    .rd_cmd_addr   (rd_cmd_addr),
    .rd_cmd_len    (rd_cmd_len),
    .wr_data_valid (wr_data_valid),
    .wr_data       (wr_data),
    .wr_keep       (wr_keep),
    .mem_en        (mem_en),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .rd_beat_keep  (rd_beat_keep),
    .rd_beat_last  (rd_beat_last),
    .wr_sts_valid  (wr_sts_valid),
    .wr_sts_data   (wr_sts_data),
    .rd_sts_valid  (rd_sts_valid),
    .rd_sts_data   (rd_sts_data)
  );

  mem_array array_inst (
    .user_clk (user_clk),
    .en       (mem_en),
    .we       (mem_we),
    .addr     (mem_addr),
    .wdata    (mem_wdata),
    .rdata    (mem_rdata)
  );

  read_stream_out rd_out_inst (
    .user_clk      (user_clk),
    .user_aresetn  (user_aresetn),
    .rd_issue      (rd_issue),
    .beat_keep     (rd_beat_keep),
    .beat_last     (rd_beat_last),
    .mem_rdata     (mem_rdata),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .rd_keep       (rd_keep),
    .rd_last       (rd_last)
  );

  mem_stats stats_inst (
    .user_clk      (user_clk),
    .user_aresetn  (user_aresetn),
    .wr_cmd_valid  (wr_cmd_valid),
    .rd_cmd_valid  (rd_cmd_valid),
    .wr_sts_valid  (wr_sts_valid),
    .wr_sts_data   (wr_sts_data),
    .rd_sts_valid  (rd_sts_valid),
    .rd_sts_data   (rd_sts_data),
    .wr_data_valid (wr_data_valid),
    .wr_keep       (wr_keep),
    .wr_last       (wr_last),
    .rd_data_valid (rd_data_valid),
    .rd_keep       (rd_keep),
    .rd_last       (rd_last),
    .stat_sel      (stat_sel),
    .stat_value    (stat_value)
  );

endmodule

`default_nettype wire

// ==== src/mem_array.sv ====
// byte-write-enabled word memory, single port, one-cycle registered read
`timescale 1ns/1ps
`default_nettype none

module mem_array (
  input  wire                              user_clk,
  input  wire                              en,
  input  wire  [mem_pkg::data_bytes-1:0]   we,
  input  wire  [mem_pkg::word_addr_w-1:0]  addr,
  input  wire  [mem_pkg::data_w-1:0]       wdata,
  output logic [mem_pkg::data_w-1:0]       rdata
);

  logic [mem_pkg::data_w-1:0] mem_q [mem_pkg::mem_words];

  // byte lanes written only where we is set
  always_ff @(posedge user_clk) begin
    if (en) begin
      for (int i = 0; i < mem_pkg::data_bytes; i++) begin
        if (we[i]) begin
          mem_q[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // read returns old contents when a write hits the same word
  always_ff @(posedge user_clk) begin
    if (en) begin
      rdata <= mem_q[addr];
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_ctrl.sv ====
// command control FSM, checks commands, sequences memory beats
// and issues read and write statuses
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
  input  wire                              user_clk,
  input  wire                              user_aresetn,
  input  wire                              wr_cmd_valid,
  input  wire  [mem_pkg::addr_w-1:0]       wr_cmd_addr,
  input  wire  [mem_pkg::len_w-1:0]        wr_cmd_len,
  input  wire                              rd_cmd_valid,
  input  wire  [mem_pkg::addr_w-1:0]       rd_cmd_addr,
  input  wire  [mem_pkg::len_w-1:0]        rd_cmd_len,
  input  wire                              wr_data_valid,
  input  wire  [mem_pkg::data_w-1:0]       wr_data,
  input  wire  [mem_pkg::data_bytes-1:0]   wr_keep,
  output logic                             mem_en,
  output logic [mem_pkg::data_bytes-1:0]   mem_we,
  output logic [mem_pkg::word_addr_w-1:0]  mem_addr,
  output logic [mem_pkg::data_w-1:0]       mem_wdata,
  output logic [mem_pkg::data_bytes-1:0]   rd_beat_keep,
  output logic                             rd_beat_last,
  output logic                             wr_sts_valid,
  output logic [mem_pkg::sts_w-1:0]        wr_sts_data,
  output logic                             rd_sts_valid,
  output logic [mem_pkg::sts_w-1:0]        rd_sts_data
);

  mem_pkg::ctrl_state_e state_q;
  mem_pkg::mem_op_e     op_q;                              // which status to raise
  logic [mem_pkg::len_w-3:0]        beats_q;               // beats still to move
  logic                             drain_q;               // read pipeline drain
  logic [mem_pkg::word_addr_w-1:0]  word_addr_q;
  logic [mem_pkg::data_bytes-1:0]   tail_keep_q;           // keep for the last read beat
  logic [mem_pkg::sts_w-1:0]        sts_q;

  logic                             cmd_valid;
  logic [mem_pkg::addr_w-1:0]       cmd_addr;
  logic [mem_pkg::len_w-1:0]        cmd_len;
  logic [mem_pkg::len_w:0]          cmd_len_up;            // len + 7 for the beat count
  logic [mem_pkg::len_w:0]          cmd_end;               // first byte past the transfer
  logic [mem_pkg::sts_w-1:0]        cmd_sts;
  logic [mem_pkg::data_bytes-1:0]   cmd_tail;
  logic                             wr_beat;
  logic                             rd_beat;

  // write command wins a tie
  assign cmd_valid  = wr_cmd_valid | rd_cmd_valid;
  assign cmd_addr   = wr_cmd_valid ? wr_cmd_addr : rd_cmd_addr;
  assign cmd_len    = wr_cmd_valid ? wr_cmd_len : rd_cmd_len;
  assign cmd_len_up = {1'b0, cmd_len} + (mem_pkg::len_w + 1)'(mem_pkg::data_bytes - 1);
  assign cmd_end    = {2'b00, cmd_addr} + {1'b0, cmd_len};

  always_comb begin
    cmd_sts = '0;
    if (cmd_addr[mem_pkg::off_w-1:0] != '0) begin
      cmd_sts[mem_pkg::sts_align_bit] = 1'b1;   // misaligned start
    end else if (cmd_len == '0) begin
      cmd_sts[mem_pkg::sts_zero_bit] = 1'b1;
    end else if (cmd_end > (mem_pkg::len_w + 1)'(mem_pkg::mem_bytes)) begin
      cmd_sts[mem_pkg::sts_range_bit] = 1'b1;   // runs off the end of memory
    end else begin
      cmd_sts[mem_pkg::sts_ok_bit] = 1'b1;      // 0x80
    end
  end

  // low len mod 8 bytes on the last beat, all bytes if it divides evenly
  always_comb begin
    cmd_tail = '1;
    if (cmd_len[mem_pkg::off_w-1:0] != '0) begin
      cmd_tail = ~({mem_pkg::data_bytes{1'b1}} << cmd_len[mem_pkg::off_w-1:0]);
    end
  end

  assign wr_beat = (state_q == mem_pkg::st_write) & wr_data_valid;
  assign rd_beat = (state_q == mem_pkg::st_read);   // one read issued every cycle

  assign mem_en       = wr_beat | rd_beat;
  assign mem_we       = wr_beat ? wr_keep : '0;
  assign mem_addr     = word_addr_q;
  assign mem_wdata    = wr_data;
  assign rd_beat_last = rd_beat & (beats_q == 1);
  assign rd_beat_keep = !rd_beat ? '0 : (rd_beat_last ? tail_keep_q : '1);
  assign wr_sts_data  = sts_q;      // held from command accept until the strobe
  assign rd_sts_data  = sts_q;

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      state_q      <= mem_pkg::st_idle;
      op_q         <= mem_pkg::op_read;
      beats_q      <= '0;
      drain_q      <= 1'b0;
      wr_sts_valid <= 1'b0;
      rd_sts_valid <= 1'b0;
    end else begin
      wr_sts_valid <= 1'b0;   // strobes
      rd_sts_valid <= 1'b0;
      case (state_q)
        mem_pkg::st_idle: begin
          if (cmd_valid) begin
            op_q    <= wr_cmd_valid ? mem_pkg::op_write : mem_pkg::op_read;
            beats_q <= cmd_len_up[mem_pkg::len_w:mem_pkg::off_w];
            drain_q <= 1'b0;
            if (!cmd_sts[mem_pkg::sts_ok_bit]) begin
              state_q <= mem_pkg::st_status;     // bad command, report at once
            end else if (wr_cmd_valid) begin
              state_q <= mem_pkg::st_write;
            end else begin
              state_q <= mem_pkg::st_read;
            end
          end
        end
        mem_pkg::st_write: begin
          if (wr_data_valid) begin
            beats_q <= beats_q - 1'b1;
            if (beats_q == 1) begin
              state_q <= mem_pkg::st_status;
            end
          end
        end
        mem_pkg::st_read: begin
          beats_q <= beats_q - 1'b1;
          if (beats_q == 1) begin
            state_q <= mem_pkg::st_status;
            drain_q <= 1'b1;   // last beat still in memory and output stages
          end
        end
        mem_pkg::st_status: begin
          if (drain_q) begin
            drain_q <= 1'b0;
          end else begin
            wr_sts_valid <= (op_q == mem_pkg::op_write);
            rd_sts_valid <= (op_q == mem_pkg::op_read);
            state_q      <= mem_pkg::st_idle;
          end
        end
        default: state_q <= mem_pkg::st_idle;
      endcase
    end
  end

  // address, tail keep and status code of the command in progress
  always_ff @(posedge user_clk) begin
    if ((state_q == mem_pkg::st_idle) && cmd_valid) begin
      word_addr_q <= cmd_addr[mem_pkg::addr_w-1:mem_pkg::off_w];
      tail_keep_q <= cmd_tail;
      sts_q       <= cmd_sts;
    end else if (mem_en) begin
      word_addr_q <= word_addr_q + 1'b1;   // next word each beat
    end
  end

endmodule

`default_nettype wire

// ==== src/mem_pkg.sv ====
// shared widths, sizes, status bits, statistic indices and enums
// for the single-clock memory access engine
`default_nettype none

package mem_pkg;

  // datapath and memory geometry
  localparam int data_w      = 64;    // stream and memory word
  localparam int data_bytes  = 8;     // bytes per word, keep width
  localparam int mem_words   = 256;   // memory depth
  localparam int mem_bytes   = 2048;  // memory size in bytes
  localparam int word_addr_w = 8;     // word address
  localparam int addr_w      = 11;    // byte address in commands
  localparam int off_w       = addr_w - word_addr_w;  // byte offset inside a word
  localparam int len_w       = 12;    // byte length in commands
  localparam int sts_w       = 8;     // status word
  localparam int stat_w      = 32;    // counter width
  localparam int stat_sel_w  = 4;     // statistic index
  localparam int num_stats   = 12;

  // status bit positions
  localparam int sts_ok_bit    = 7;
  localparam int sts_range_bit = 0;
  localparam int sts_align_bit = 1;
  localparam int sts_zero_bit  = 2;

  // statistic indices
  localparam int stat_wr_cmd   = 0;
  localparam int stat_wr_sts   = 1;
  localparam int stat_wr_err   = 2;
  localparam int stat_rd_cmd   = 3;
  localparam int stat_rd_sts   = 4;
  localparam int stat_rd_err   = 5;
  localparam int stat_wr_word  = 6;
  localparam int stat_wr_pkt   = 7;
  localparam int stat_wr_bytes = 8;
  localparam int stat_rd_word  = 9;
  localparam int stat_rd_pkt   = 10;
  localparam int stat_rd_bytes = 11;

  typedef enum logic [1:0] {st_idle, st_write, st_read, st_status} ctrl_state_e;

  typedef enum logic {op_read, op_write} mem_op_e;

endpackage

`default_nettype wire

// ==== src/mem_stats.sv ====
// traffic and error counters for commands, statuses and both data streams,
// read out by index through a two-stage register
`timescale 1ns/1ps
`default_nettype none

module mem_stats (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  input  wire                             wr_cmd_valid,
  input  wire                             rd_cmd_valid,
  input  wire                             wr_sts_valid,
  input  wire  [mem_pkg::sts_w-1:0]       wr_sts_data,
  input  wire                             rd_sts_valid,
  input  wire  [mem_pkg::sts_w-1:0]       rd_sts_data,
  input  wire                             wr_data_valid,
  input  wire  [mem_pkg::data_bytes-1:0]  wr_keep,
  input  wire                             wr_last,
  input  wire                             rd_data_valid,
  input  wire  [mem_pkg::data_bytes-1:0]  rd_keep,
  input  wire                             rd_last,
  input  wire  [mem_pkg::stat_sel_w-1:0]  stat_sel,
  output logic [mem_pkg::stat_w-1:0]      stat_value
);

  logic [mem_pkg::stat_w-1:0]      cnt_q [mem_pkg::num_stats];
  logic [mem_pkg::stat_w-1:0]      cnt_add [mem_pkg::num_stats];   // this cycle's increment
  logic [mem_pkg::stat_sel_w-1:0]  sel_q;

  // number of bytes kept in a beat
  function automatic logic [mem_pkg::stat_w-1:0] keep_bytes(
    input logic [mem_pkg::data_bytes-1:0] keep
  );
    logic [mem_pkg::stat_w-1:0] n;
    n = '0;
    for (int i = 0; i < mem_pkg::data_bytes; i++) begin
      n = n + keep[i];
    end
    return n;
  endfunction

  always_comb begin
    cnt_add[mem_pkg::stat_wr_cmd]   = mem_pkg::stat_w'(wr_cmd_valid);   // good and bad alike
    cnt_add[mem_pkg::stat_wr_sts]   = mem_pkg::stat_w'(wr_sts_valid);
    cnt_add[mem_pkg::stat_wr_err]   =
      mem_pkg::stat_w'(wr_sts_valid & ~wr_sts_data[mem_pkg::sts_ok_bit]);
    cnt_add[mem_pkg::stat_rd_cmd]   = mem_pkg::stat_w'(rd_cmd_valid);
    cnt_add[mem_pkg::stat_rd_sts]   = mem_pkg::stat_w'(rd_sts_valid);
    cnt_add[mem_pkg::stat_rd_err]   =
      mem_pkg::stat_w'(rd_sts_valid & ~rd_sts_data[mem_pkg::sts_ok_bit]);
    cnt_add[mem_pkg::stat_wr_word]  = mem_pkg::stat_w'(wr_data_valid);
    cnt_add[mem_pkg::stat_wr_pkt]   = mem_pkg::stat_w'(wr_data_valid & wr_last);
    cnt_add[mem_pkg::stat_wr_bytes] = wr_data_valid ? keep_bytes(wr_keep) : '0;
    cnt_add[mem_pkg::stat_rd_word]  = mem_pkg::stat_w'(rd_data_valid);
    cnt_add[mem_pkg::stat_rd_pkt]   = mem_pkg::stat_w'(rd_data_valid & rd_last);
    cnt_add[mem_pkg::stat_rd_bytes] = rd_data_valid ? keep_bytes(rd_keep) : '0;
  end

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      for (int i = 0; i < mem_pkg::num_stats; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < mem_pkg::num_stats; i++) begin
        cnt_q[i] <= cnt_q[i] + cnt_add[i];
      end
    end
  end

  // index register, then value register
  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      sel_q      <= '0;
      stat_value <= '0;
    end else begin
      sel_q <= stat_sel;
      if (sel_q < mem_pkg::stat_sel_w'(mem_pkg::num_stats)) begin
        stat_value <= cnt_q[sel_q];
      end else begin
        stat_value <= '0;   // unused index
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/read_stream_out.sv ====
// read stream output stage, lines up keep and last with memory latency
// and registers the beat onto the read data stream
`timescale 1ns/1ps
`default_nettype none

module read_stream_out (
  input  wire                             user_clk,
  input  wire                             user_aresetn,
  input  wire                             rd_issue,
  input  wire  [mem_pkg::data_bytes-1:0]  beat_keep,
  input  wire                             beat_last,
  input  wire  [mem_pkg::data_w-1:0]      mem_rdata,
  output logic                            rd_data_valid,
  output logic [mem_pkg::data_w-1:0]      rd_data,
  output logic [mem_pkg::data_bytes-1:0]  rd_keep,
  output logic                            rd_last
);

  logic                            issue_d;   // beat now on mem_rdata
  logic [mem_pkg::data_bytes-1:0]  keep_d;
  logic                            last_d;

  always_ff @(posedge user_clk) begin
    if (!user_aresetn) begin
      issue_d       <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      issue_d       <= rd_issue;
      rd_data_valid <= issue_d;
    end
  end

  // side-band follows the read into the memory stage
  always_ff @(posedge user_clk) begin
    if (rd_issue) begin
      keep_d <= beat_keep;
      last_d <= beat_last;
    end
  end

  // output beat, held between strobes
  always_ff @(posedge user_clk) begin
    if (issue_d) begin
      rd_data <= mem_rdata;
      rd_keep <= keep_d;
      rd_last <= last_d;
    end
  end

endmodule

`default_nettype wire
